// ==== verilog/frontEndPkg.sv ====
package frontEndPkg;

    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [4:0] regIndexT;
    typedef logic [4:0] excCodeT;

    // Primary opcode field, bits 31:26.
    localparam logic [5:0] opSpecial = 6'd0;
    localparam logic [5:0] opJ = 6'd2;
    localparam logic [5:0] opOri = 6'd13;
    localparam logic [5:0] opLui = 6'd15;

    // Function field of SPECIAL, bits 5:0.
    localparam logic [5:0] functJr = 6'd8;
    localparam logic [5:0] functSyscall = 6'd12;

    localparam excCodeT excAdel = 5'd4;      // Fetch address error.
    localparam excCodeT excSyscall = 5'd8;

    typedef enum logic [2:0] {
        classNop,
        classOri,
        classLui,
        classJ,
        classJr,
        classSyscall
    } instrClassT;

endpackage

// ==== verilog/instructionFetch.sv ====
`timescale 1ns/1ps

module instructionFetch
    import frontEndPkg::*;
#(
    parameter addrT resetVector = 32'hBFC00000
) (
    input  logic clk,
    input  logic reset,

    input  logic absJump,
    input  addrT absJumpAddress,

    input  logic stall,
    input  logic exception,

    output addrT fetchPc,
    output wordT fetchInstr,
    output logic fetchBubble,
    output logic fetchAdel,

    output addrT instSramAddr,
    output logic instSramReadEn,
    input  wordT instSramRdata,
    input  logic instSramValid
);

    addrT pc;
    addrT pcNext;
    addrT pendingJumpAddr;
    addrT jumpTarget;
    logic active;
    logic busy;
    logic pendingJump;
    logic pendingJumpNext;
    logic pendingExc;
    logic pendingExcNext;
    logic canIssue;
    logic jumpReq;
    logic excReq;

    assign canIssue = active && (instSramValid || !busy);   // No read left outstanding.
    assign jumpReq = absJump || pendingJump;
    assign excReq = exception || pendingExc;
    assign jumpTarget = pendingJump ? pendingJumpAddr : absJumpAddress;

    assign fetchPc = pc;
    assign fetchInstr = instSramRdata;
    assign fetchAdel = pc[1:0] != 2'b00;
    assign instSramAddr = pcNext;

    always_comb begin
        pcNext = pc;
        instSramReadEn = 1'b0;
        fetchBubble = 1'b1;
        pendingJumpNext = jumpReq;
        pendingExcNext = excReq;
        if (canIssue) begin
            if (jumpReq) begin
                // Data that returns with a redirect is from the old path.
                if (!stall) begin
                    pcNext = jumpTarget;
                    instSramReadEn = jumpTarget[1:0] == 2'b00;
                    pendingJumpNext = 1'b0;
                    pendingExcNext = 1'b0;
                end
            end else if (!excReq) begin
                fetchBubble = !(instSramValid || fetchAdel);
                if (!fetchBubble && !stall) begin
                    pcNext = pc + 32'd4;
                end
                instSramReadEn = pcNext[1:0] == 2'b00;    // Re-reads pc when held.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            active <= 1'b0;
            busy <= 1'b0;
            pendingJump <= 1'b0;
            pendingExc <= 1'b0;
        end else begin
            pc <= pcNext;
            active <= 1'b1;
            busy <= instSramReadEn || (busy && !instSramValid);
            pendingJump <= pendingJumpNext;
            pendingExc <= pendingExcNext;
        end
    end

    // The oldest redirect is kept until it is taken.
    always_ff @(posedge clk) begin
        if (absJump && !pendingJump) begin
            pendingJumpAddr <= absJumpAddress;
        end
    end

endmodule

// ==== verilog/instructionDecode.sv ====
`timescale 1ns/1ps

module instructionDecode
    import frontEndPkg::*;
(
    input  logic clk,
    input  logic reset,

    input  addrT fetchPc,
    input  wordT fetchInstr,
    input  logic fetchBubble,
    input  logic fetchAdel,

    input  logic stall,
    input  logic flush,

    output logic decValid,
    output addrT decPc,
    output logic decAdel,
    output instrClassT decClass,
    output regIndexT decRs,
    output regIndexT decRt,
    output logic [15:0] decImm,
    output logic [25:0] decTarget
);

    wordT instrReg;
    instrClassT fetchClass;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic capture;

    assign opcode = fetchInstr[31:26];
    assign funct = fetchInstr[5:0];
    assign capture = !fetchBubble && !stall && !flush;

    always_comb begin
        fetchClass = classNop;
        if (!fetchAdel) begin       // Bad address carries no instruction.
            case (opcode)
                opSpecial: begin
                    if (funct == functJr) begin
                        fetchClass = classJr;
                    end else if (funct == functSyscall) begin
                        fetchClass = classSyscall;
                    end
                end
                opJ:     fetchClass = classJ;
                opOri:   fetchClass = classOri;
                opLui:   fetchClass = classLui;
                default: fetchClass = classNop;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (flush) begin
            decValid <= 1'b0;
        end else if (!stall) begin
            decValid <= !fetchBubble;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            decPc <= fetchPc;
            instrReg <= fetchInstr;
            decAdel <= fetchAdel;
            decClass <= fetchClass;
        end
    end

    assign decRs = instrReg[25:21];
    assign decRt = instrReg[20:16];
    assign decImm = instrReg[15:0];
    assign decTarget = instrReg[25:0];

endmodule

// ==== verilog/controlFlowExecute.sv ====
`timescale 1ns/1ps

module controlFlowExecute
    import frontEndPkg::*;
#(
    parameter addrT exceptionVector = 32'hBFC00380
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,

    input  logic decValid,
    input  addrT decPc,
    input  logic decAdel,
    input  instrClassT decClass,
    input  regIndexT decRs,
    input  regIndexT decRt,
    input  logic [15:0] decImm,
    input  logic [25:0] decTarget,

    output logic absJump,
    output addrT absJumpAddress,
    output logic exception,
    output logic flush,

    output logic exValid,
    output addrT exPc,
    output logic exWriteEnable,
    output regIndexT exWriteReg,
    output wordT exWriteData,
    output logic exExcValid,
    output excCodeT exExcCode
);

    wordT regFile [32];
    wordT rsValue;
    addrT pcPlus4;
    logic act;
    logic vectorPending;

    assign act = decValid && !stall;
    assign rsValue = (decRs == 5'd0) ? 32'h0 : regFile[decRs];     // r0 reads as zero.
    assign pcPlus4 = decPc + 32'd4;

    always_comb begin
        absJump = 1'b0;
        absJumpAddress = exceptionVector;
        exception = 1'b0;
        exValid = act;
        exPc = decPc;
        exWriteEnable = 1'b0;
        exWriteReg = decRt;
        exWriteData = rsValue | {16'h0000, decImm};
        exExcValid = 1'b0;
        exExcCode = excSyscall;
        if (vectorPending) begin
            absJump = !stall;       // Vector redirect.
        end else if (act) begin
            if (decAdel) begin
                exception = 1'b1;
                exExcValid = 1'b1;
                exExcCode = excAdel;
            end else begin
                case (decClass)
                    classOri: begin
                        exWriteEnable = decRt != 5'd0;
                    end
                    classLui: begin
                        exWriteEnable = decRt != 5'd0;
                        exWriteData = {decImm, 16'h0000};
                    end
                    classJ: begin
                        absJump = 1'b1;
                        absJumpAddress = {pcPlus4[31:28], decTarget, 2'b00};
                    end
                    classJr: begin
                        absJump = 1'b1;
                        absJumpAddress = rsValue;
                    end
                    classSyscall: begin
                        exception = 1'b1;
                        exExcValid = 1'b1;
                        exExcCode = excSyscall;
                    end
                    default: begin
                        exWriteEnable = 1'b0;
                    end
                endcase
            end
        end
    end

    assign flush = absJump || exception;

    always_ff @(posedge clk) begin
        if (reset) begin
            vectorPending <= 1'b0;
        end else if (exception) begin
            vectorPending <= 1'b1;
        end else if (!stall) begin
            vectorPending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exWriteEnable) begin
            regFile[exWriteReg] <= exWriteData;
        end
    end

endmodule

// ==== verilog/retireResult.sv ====
`timescale 1ns/1ps

module retireResult
    import frontEndPkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic exValid,
    input  addrT exPc,
    input  logic exWriteEnable,
    input  regIndexT exWriteReg,
    input  wordT exWriteData,
    input  logic exExcValid,
    input  excCodeT exExcCode,

    output logic retireValid,
    output addrT retirePc,
    output logic retireWriteEnable,
    output regIndexT retireWriteReg,
    output wordT retireWriteData,
    output logic retireExc,
    output excCodeT retireExcCode
);

    logic [1:0] excRun;     // Consecutive execute cycles of one exception.
    logic repeatExc;

    assign repeatExc = exExcValid && (excRun != 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
            retireExc <= 1'b0;
            retireWriteEnable <= 1'b0;
            excRun <= 2'd0;
        end else begin
            retireValid <= exValid && !repeatExc;
            retireExc <= exExcValid && !repeatExc;
            retireWriteEnable <= exWriteEnable;
            if (!exExcValid) begin
                excRun <= 2'd0;
            end else if (excRun != 2'd3) begin
                excRun <= excRun + 2'd1;    // Saturates.
            end
        end
    end

    always_ff @(posedge clk) begin
        retirePc <= exPc;       // EPC on an exception.
        retireWriteReg <= exWriteReg;
        retireWriteData <= exWriteData;
        retireExcCode <= exExcCode;
    end

endmodule

// ==== verilog/fetchSubsystem.sv ====
`timescale 1ns/1ps

module fetchSubsystem
    import frontEndPkg::*;
#(
    parameter addrT resetVector = 32'hBFC00000,
    parameter addrT exceptionVector = 32'hBFC00380
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,

    output addrT instSramAddr,
    output logic instSramReadEn,
    input  wordT instSramRdata,
    input  logic instSramValid,

    output logic retireValid,
    output addrT retirePc,
    output logic retireWriteEnable,
    output regIndexT retireWriteReg,
    output wordT retireWriteData,
    output logic retireExc,
    output excCodeT retireExcCode
);

    addrT fetchPc;
    wordT fetchInstr;
    logic fetchBubble;
    logic fetchAdel;

    logic decValid;
    addrT decPc;
    logic decAdel;
    instrClassT decClass;
    regIndexT decRs;
    regIndexT decRt;
    logic [15:0] decImm;
    logic [25:0] decTarget;

    logic absJump;
    addrT absJumpAddress;
    logic exception;
    logic flush;

    logic exValid;
    addrT exPc;
    logic exWriteEnable;
    regIndexT exWriteReg;
    wordT exWriteData;
    logic exExcValid;
    excCodeT exExcCode;

    instructionFetch #(
        .resetVector(resetVector)
    ) instructionFetch_inst (
        .clk(clk),
        .reset(reset),
        .absJump(absJump),
        .absJumpAddress(absJumpAddress),
        .stall(stall),
        .exception(exception),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr),
        .fetchBubble(fetchBubble),
        .fetchAdel(fetchAdel),
        .instSramAddr(instSramAddr),
        .instSramReadEn(instSramReadEn),
        .instSramRdata(instSramRdata),
        .instSramValid(instSramValid)
    );

    instructionDecode instructionDecode_inst (
        .clk(clk),
        .reset(reset),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr),
        .fetchBubble(fetchBubble),
        .fetchAdel(fetchAdel),
        .stall(stall),
        .flush(flush),
        .decValid(decValid),
        .decPc(decPc),
        .decAdel(decAdel),
        .decClass(decClass),
        .decRs(decRs),
        .decRt(decRt),
        .decImm(decImm),
        .decTarget(decTarget)
    );

    controlFlowExecute #(
        .exceptionVector(exceptionVector)
    ) controlFlowExecute_inst (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .decValid(decValid),
        .decPc(decPc),
        .decAdel(decAdel),
        .decClass(decClass),
        .decRs(decRs),
        .decRt(decRt),
        .decImm(decImm),
        .decTarget(decTarget),
        .absJump(absJump),
        .absJumpAddress(absJumpAddress),
        .exception(exception),
        .flush(flush),
        .exValid(exValid),
        .exPc(exPc),
        .exWriteEnable(exWriteEnable),
        .exWriteReg(exWriteReg),
        .exWriteData(exWriteData),
        .exExcValid(exExcValid),
        .exExcCode(exExcCode)
    );

    retireResult retireResult_inst (
        .clk(clk),
        .reset(reset),
        .exValid(exValid),
        .exPc(exPc),
        .exWriteEnable(exWriteEnable),
        .exWriteReg(exWriteReg),
        .exWriteData(exWriteData),
        .exExcValid(exExcValid),
        .exExcCode(exExcCode),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireWriteEnable(retireWriteEnable),
        .retireWriteReg(retireWriteReg),
        .retireWriteData(retireWriteData),
        .retireExc(retireExc),
        .retireExcCode(retireExcCode)
    );

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod = 50     // 100 ns period.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

// ==== tests/fetchSubsystem_properties.sv ====
`timescale 1ns/1ps

module fetchSubsystem_properties (
    input logic clk,
    input logic reset,
    input logic readEn,
    input logic readValid,
    input logic retireValid,
    input logic retireExc
);

    logic readOutstanding;

    // Tracks the SRAM bus from its own strobes.
    always_ff @(posedge clk) begin
        if (reset) begin
            readOutstanding <= 1'b0;
        end else begin
            readOutstanding <= readEn || (readOutstanding && !readValid);
        end
    end

    // Only one SRAM read in flight.
    strobeWhileBusy: assert property (
        @(posedge clk) disable iff (reset) readEn |-> (!readOutstanding || readValid)
    ) else $error("read strobe while a read is outstanding");

    excWithoutRetire: assert property (
        @(posedge clk) disable iff (reset) retireExc |-> retireValid
    ) else $error("exception reported without a retire");

endmodule

bind instructionFetch fetchSubsystem_properties fetchProps (
    .clk(clk),
    .reset(reset),
    .readEn(instSramReadEn),
    .readValid(instSramValid),
    .retireValid(1'b0),
    .retireExc(1'b0)
);

bind retireResult fetchSubsystem_properties resultProps (
    .clk(clk),
    .reset(reset),
    .readEn(1'b0),
    .readValid(1'b0),
    .retireValid(retireValid),
    .retireExc(retireExc)
);

// ==== tests/fetchSubsystemTb.sv ====
`timescale 1ns/1ps

module fetchSubsystemTb
    import frontEndPkg::*;
();

    localparam int retireTimeout = 300;

    logic clk;
    logic reset = 1'b1;
    logic stall = 1'b0;
    addrT instSramAddr;
    logic instSramReadEn;
    wordT instSramRdata = 32'h0;
    logic instSramValid = 1'b0;
    logic retireValid;
    addrT retirePc;
    logic retireWriteEnable;
    regIndexT retireWriteReg;
    wordT retireWriteData;
    logic retireExc;
    excCodeT retireExcCode;

    logic [31:0] testData [0:255];
    wordT progMem [addrT];
    logic [31:0] stallMask = 32'h0;
    logic stallPrev;
    logic reqSeen = 1'b0;
    addrT reqAddr = 32'h0;
    addrT readAddr;
    int readCount = 0;
    int seed = 32'h9f6b;
    int errorCount = 0;
    int testsFailed = 0;

    clockGen clockGen_inst (.clk(clk));

    fetchSubsystem fetchSubsystem_inst (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .instSramAddr(instSramAddr),
        .instSramReadEn(instSramReadEn),
        .instSramRdata(instSramRdata),
        .instSramValid(instSramValid),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireWriteEnable(retireWriteEnable),
        .retireWriteReg(retireWriteReg),
        .retireWriteData(retireWriteData),
        .retireExc(retireExc),
        .retireExcCode(retireExcCode)
    );

    task automatic checkAddr(input string name, input addrT expected, input addrT actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkReg(input string name, input regIndexT expected, input regIndexT actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkExc(input string name, input excCodeT expected, input excCodeT actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    // Request is sampled mid-cycle.
    always @(negedge clk) begin
        reqSeen = instSramReadEn;
        reqAddr = instSramAddr;
    end

    // SRAM model, latency 1 to 4 cycles.
    always @(posedge clk) begin
        logic inReset;
        int lat;
        inReset = reset;
        #1;
        instSramValid = 1'b0;
        if (inReset) begin
            readCount = 0;
        end else begin
            if (reqSeen) begin
                if (readCount != 0) begin
                    $display("SRAM read strobe at %h while a read is still outstanding", reqAddr);
                    errorCount++;
                end
                lat = 1 + int'($unsigned($random(seed)) % 32'd4);
                readCount = lat;
                readAddr = reqAddr;
            end
            if (readCount != 0) begin
                readCount--;
                if (readCount == 0) begin
                    instSramValid = 1'b1;
                    instSramRdata = progMem.exists(readAddr) ? progMem[readAddr] : ~readAddr;
                end
            end
        end
    end

    always @(posedge clk) begin
        logic inReset;
        logic [4:0] cycle;
        inReset = reset;
        #1;
        if (inReset) begin
            cycle = 5'd0;
            stall = 1'b0;
        end else begin
            stall = stallMask[cycle];
            cycle = cycle + 5'd1;
        end
    end

    task automatic waitRetire(output logic found);
        int n;
        found = 1'b0;
        for (n = 0; n < retireTimeout && !found; n++) begin
            @(negedge clk);
            if (retireValid && stallPrev) begin
                $display("Retire at %h in a cycle after stall was held", retirePc);
                errorCount++;
            end
            stallPrev = stall;
            found = retireValid;
        end
    endtask

    task automatic runTest(input int t, input logic [31:0] mask, input int nTrace);
        int startErrors;
        int k;
        int base;
        logic [31:0] info;
        logic found;
        string name;
        startErrors = errorCount;
        @(posedge clk);
        #1;
        reset = 1'b1;
        stallMask = mask;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        stallPrev = 1'b0;
        for (k = 0; k < nTrace; k++) begin
            base = 97 + 3 * k;
            waitRetire(found);
            if (!found) begin
                $display("Test %0d: nothing retired within %0d cycles for trace entry %0d",
                         t, retireTimeout, k);
                errorCount++;
                break;
            end
            info = testData[base + 1];
            name = $sformatf("test %0d entry %0d", t, k);
            checkAddr({name, " pc"}, testData[base], retirePc);
            if (info[31]) begin
                if (!retireExc) begin
                    $display("Test %0d entry %0d: exception expected but not reported", t, k);
                    errorCount++;
                end else begin
                    checkExc({name, " code"}, info[4:0], retireExcCode);
                end
            end else if (retireExc) begin
                $display("Test %0d entry %0d: unexpected exception reported", t, k);
                errorCount++;
            end
            if (info[16] !== retireWriteEnable) begin
                $display("[ERROR] %s write enable: expected %b, actual %b",
                         name, info[16], retireWriteEnable);
                errorCount++;
            end else if (info[16]) begin
                checkReg({name, " reg"}, info[4:0], retireWriteReg);
                checkWord({name, " data"}, testData[base + 2], retireWriteData);
            end
        end
        if (errorCount != startErrors) begin
            testsFailed++;
        end
        $display("Test %0d, stall mask %h: %0d errors", t, mask, errorCount - startErrors);
    endtask

    initial begin
        int nProg;
        int nTests;
        int nTrace;
        int i;
        $readmemh("tests/fetchSubsystem_testdata.txt", testData);
        nProg = int'(testData[0]);
        nTests = int'(testData[64]);
        nTrace = int'(testData[96]);
        for (i = 0; i < nProg; i++) begin
            progMem[testData[1 + 2 * i]] = testData[2 + 2 * i];
        end
        if (nProg == 0 || nTests == 0 || nTrace == 0) begin
            $display("Test data file is missing or empty");
            errorCount++;
        end
        for (i = 0; i < nTests; i++) begin
            runTest(i, testData[65 + i], nTrace);
        end
        $display("%0d tests, %0d failed, %0d errors", nTests, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== fetchSubsystem.f ====
verilog/frontEndPkg.sv
verilog/instructionFetch.sv
verilog/instructionDecode.sv
verilog/controlFlowExecute.sv
verilog/retireResult.sv
verilog/fetchSubsystem.sv
tests/clockGen.sv
tests/fetchSubsystem_properties.sv
tests/fetchSubsystemTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = fetchSubsystemTb
FILELIST  = fetchSubsystem.f
BUILD     = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard verilog/*.sv) $(wildcard tests/*.sv) tests/fetchSubsystem_testdata.txt

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/fetchSubsystem_testdata.txt ====
// @000 pair count, then address and instruction pairs.
// @040 test count, then one stall mask per test (bit n stalls cycle n mod 32).
// @060 trace count, then pc, info, data (info 800000cc exception cc, 000100rr write rr).
@000
0000000F
BFC00000 3C011234
BFC00004 34225678
BFC00008 34430000
BFC0000C 0BF00040
BFC00010 3C09DEAD
BFC00100 3C04BFC0
BFC00104 34840200
BFC00108 00800008
BFC0010C 3C09DEAD
BFC00200 0000000C
BFC00204 3C09DEAD
BFC00380 34050042
BFC00384 34860003
BFC00388 00C00008
BFC0038C 3C09DEAD
@040
00000003
00000000
00C0300C
11111111
@060
0000000D
BFC00000 00010001 12340000
BFC00004 00010002 12345678
BFC00008 00010003 12345678
BFC0000C 00000000 00000000
BFC00100 00010004 BFC00000
BFC00104 00010004 BFC00200
BFC00108 00000000 00000000
BFC00200 80000008 00000000
BFC00380 00010005 00000042
BFC00384 00010006 BFC00203
BFC00388 00000000 00000000
BFC00203 80000004 00000000
BFC00380 00010005 00000042
